// File: hdl/sdram_pkg.sv
// SDRAM word address, data word and byte mask types
package sdram_pkg;

    // Bank geometry
    localparam int SDRAM_AW = 23;  // Word address bits
    localparam int SDRAM_DW = 16;  // Data bits per word
    localparam int SDRAM_MW = SDRAM_DW / 8;

    // Word address inside one bank
    typedef logic [SDRAM_AW-1:0] sdram_addr_t;

    // One SDRAM data word, upper byte first on the board
    typedef logic [SDRAM_DW-1:0] sdram_data_t;

    // Byte write mask
    // A bit set to one keeps the stored byte, a zero lets the
    // byte from the write data through
    typedef logic [SDRAM_MW-1:0] sdram_mask_t;

endpackage

// File: hdl/mem_map_pkg.sv
// Region offsets in SDRAM and client address types of the memory map
package mem_map_pkg;

    // Client address widths
    localparam int RAM_AW = 17;  // Main CPU and video DMA, word address
    localparam int SND_AW = 16;  // Sound CPU, byte address
    localparam int PCM_AW = 18;  // PCM samples, byte address

    // Bank 0 layout
    localparam sdram_pkg::sdram_addr_t VRAM_OFFSET = 23'h20_0000;
    localparam sdram_pkg::sdram_addr_t WRAM_OFFSET = 23'h30_0000;
    localparam sdram_pkg::sdram_addr_t SND_OFFSET  = 23'h38_0000;

    // Bank 1 holds only the samples
    localparam sdram_pkg::sdram_addr_t PCM_OFFSET  = 23'h00_0000;

    typedef logic [RAM_AW-1:0] ram_addr_t;
    typedef logic [SND_AW-1:0] snd_addr_t;
    typedef logic [PCM_AW-1:0] pcm_addr_t;

endpackage

// File: hdl/slot_if.sv
// Request and reply signals between a client slot and its bank arbiter
`timescale 1ns/1ns

interface slot_if;
    import sdram_pkg::*;

    logic        req;     // Held until done
    logic        we;
    sdram_addr_t addr;
    sdram_data_t din;
    sdram_mask_t wrmask;  // Ones keep the byte
    logic        done;    // One cycle pulse
    sdram_data_t rdata;   // Valid with done on reads

    modport client (
        output req, we, addr, din, wrmask,
        input  done, rdata
    );

    modport arbiter (
        input  req, we, addr, din, wrmask,
        output done, rdata
    );

endinterface

// File: hdl/mem_slot.sv
// Cached client slot with offset add, hit detection, miss request and byte select
`timescale 1ns/1ns

module mem_slot #(
    parameter int                    AW     = 16,
    parameter int                    DW     = 16,
    parameter sdram_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cs,
    input  logic                  we,
    input  logic [AW-1:0]         addr,
    input  sdram_pkg::sdram_data_t din,
    input  sdram_pkg::sdram_mask_t wrmask,
    input  logic                  clr,     // Drops the cached word
    output logic                  ok,
    output logic [DW-1:0]         dout,
    slot_if.client                bus
);
    import sdram_pkg::*;

    // 8-bit clients address bytes, so the LSB is not part of the word address
    localparam int WAW = (DW == 8) ? AW - 1 : AW;

    logic [WAW-1:0] word_idx;
    sdram_addr_t    waddr;
    logic           hit, served, start;

    logic           req_q, ok_r, cache_valid;
    sdram_addr_t    cache_addr;
    sdram_data_t    cache_data;
    logic [AW-1:0]  ok_addr;  // Client address of the last answer
    logic           ok_we;
    sdram_addr_t    bus_addr;
    logic           bus_we;
    sdram_data_t    bus_din;
    sdram_mask_t    bus_wrmask;

    assign word_idx = addr[AW-1:AW-WAW];
    assign waddr    = OFFSET + sdram_addr_t'(word_idx);
    assign hit      = cache_valid && (cache_addr == waddr);
    assign served   = ok_r && (addr == ok_addr) && (we == ok_we);
    assign start    = cs && !served && !req_q;
    assign ok       = cs && served;  // Falls with cs or a new address

    assign bus.req    = req_q;
    assign bus.we     = bus_we;
    assign bus.addr   = bus_addr;
    assign bus.din    = bus_din;
    assign bus.wrmask = bus_wrmask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q       <= 1'b0;
            ok_r        <= 1'b0;
            cache_valid <= 1'b0;
        end else begin
            if (req_q) begin
                if (bus.done) begin
                    req_q       <= 1'b0;
                    ok_r        <= 1'b1;
                    cache_valid <= !bus_we;  // Writes leave the cache empty
                end
            end else if (start) begin
                ok_r  <= hit && !we;
                req_q <= !(hit && !we);
            end else if (!cs) begin
                ok_r <= 1'b0;
            end
            if (clr) cache_valid <= 1'b0;
        end
    end

    // Request fields and cached word
    always_ff @(posedge clk) begin
        if (start) begin
            ok_addr    <= addr;
            ok_we      <= we;
            bus_addr   <= waddr;
            bus_we     <= we;
            bus_din    <= din;
            bus_wrmask <= wrmask;
        end
        if (req_q && bus.done && !bus_we) begin
            cache_addr <= bus_addr;
            cache_data <= bus.rdata;
        end
    end

    generate
        if (DW == 8) begin : g_byte
            // Even byte sits in the upper half
            assign dout = addr[0] ? cache_data[7:0] : cache_data[15:8];
        end else begin : g_word
            assign dout = cache_data;
        end
    endgenerate

endmodule

// File: hdl/bank_arbiter.sv
// Fixed-priority arbiter running one SDRAM access at a time for one bank
`timescale 1ns/1ns

module bank_arbiter #(
    parameter int NSLOT = 1
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   ack,
    input  logic                   rdy,
    input  sdram_pkg::sdram_data_t data_read,
    output sdram_pkg::sdram_addr_t sdram_addr,
    output logic                   sdram_rd,
    output logic                   sdram_wr,
    output sdram_pkg::sdram_data_t sdram_din,
    output sdram_pkg::sdram_mask_t sdram_mask,
    slot_if.arbiter                slots [NSLOT]
);
    import sdram_pkg::*;

    localparam int GW = (NSLOT > 1) ? $clog2(NSLOT) : 1;

    typedef enum logic [1:0] {idle, wait_ack, wait_rdy} state_t;

    state_t           state;
    logic [NSLOT-1:0] req_v, we_v;
    sdram_addr_t      addr_a [NSLOT];
    sdram_data_t      din_a  [NSLOT];
    sdram_mask_t      mask_a [NSLOT];
    logic [GW-1:0]    grant, pick;
    logic             any_req, grant_en, rd_done, done_q;
    sdram_data_t      rdata_q;

    // Flatten the slot array
    for (genvar i = 0; i < NSLOT; i++) begin : g_slot
        assign req_v[i]       = slots[i].req;
        assign we_v[i]        = slots[i].we;
        assign addr_a[i]      = slots[i].addr;
        assign din_a[i]       = slots[i].din;
        assign mask_a[i]      = slots[i].wrmask;
        assign slots[i].done  = done_q && (grant == GW'(i));
        assign slots[i].rdata = rdata_q;
    end

    // Lowest index wins
    always_comb begin
        pick = '0;
        for (int i = NSLOT - 1; i >= 0; i--) begin
            if (req_v[i]) pick = GW'(i);
        end
    end

    assign any_req  = |req_v;
    // No grant while done is out, the finished slot still shows req
    assign grant_en = (state == idle) && any_req && !done_q;
    // Data may come in the same cycle as ack
    assign rd_done  = rdy && ((state == wait_rdy) || (state == wait_ack && ack && sdram_rd));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= idle;
            sdram_rd <= 1'b0;
            sdram_wr <= 1'b0;
            done_q   <= 1'b0;
            grant    <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                idle: if (grant_en) begin
                    grant    <= pick;
                    sdram_rd <= !we_v[pick];
                    sdram_wr <= we_v[pick];
                    state    <= wait_ack;
                end
                wait_ack: if (ack) begin
                    sdram_rd <= 1'b0;
                    sdram_wr <= 1'b0;
                    if (sdram_wr || rd_done) begin
                        done_q <= 1'b1;  // Write ends at ack
                        state  <= idle;
                    end else begin
                        state <= wait_rdy;
                    end
                end
                wait_rdy: if (rd_done) begin
                    done_q <= 1'b1;
                    state  <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_en) begin
            sdram_addr <= addr_a[pick];
            sdram_din  <= din_a[pick];
            sdram_mask <= mask_a[pick];
        end
        if (rd_done) rdata_q <= data_read;
    end

endmodule

// File: hdl/mem_map_top.sv
// Memory map top with bank 0 and bank 1 slots, main RAM offset select and refresh enable
`timescale 1ns/1ns

module mem_map_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    lvbl,
    input  logic                    vram_rfsh_en,
    input  logic                    vram_clr,
    // Main CPU
    input  logic                    main_ram_cs,
    input  logic                    main_vram_cs,
    input  logic                    main_rnw,
    input  mem_map_pkg::ram_addr_t  main_ram_addr,
    input  sdram_pkg::sdram_data_t  main_dout,
    input  sdram_pkg::sdram_mask_t  dsn,
    output logic                    main_ram_ok,
    output sdram_pkg::sdram_data_t  main_ram_data,
    // Video DMA
    input  logic                    vram_dma_cs,
    input  mem_map_pkg::ram_addr_t  vram_dma_addr,
    output logic                    vram_dma_ok,
    output sdram_pkg::sdram_data_t  vram_dma_data,
    // Sound CPU and PCM
    input  logic                    snd_cs,
    input  mem_map_pkg::snd_addr_t  snd_addr,
    output logic                    snd_ok,
    output logic [7:0]              snd_data,
    input  logic                    pcm_cs,
    input  mem_map_pkg::pcm_addr_t  pcm_addr,
    output logic                    pcm_ok,
    output logic [7:0]              pcm_data,
    // Bank 0, read and write
    output sdram_pkg::sdram_addr_t  ba0_addr,
    output logic                    ba0_rd,
    output logic                    ba0_wr,
    output sdram_pkg::sdram_data_t  ba0_din,
    output sdram_pkg::sdram_mask_t  ba0_din_m,
    input  logic                    ba0_ack,
    input  logic                    ba0_rdy,
    // Bank 1, read only
    output sdram_pkg::sdram_addr_t  ba1_addr,
    output logic                    ba1_rd,
    input  logic                    ba1_ack,
    input  logic                    ba1_rdy,
    input  sdram_pkg::sdram_data_t  data_read,
    output logic                    refresh_en
);
    import sdram_pkg::*;
    import mem_map_pkg::*;

    sdram_addr_t main_addr;
    logic        main_cs;

    slot_if b0_bus [3] ();  // Main, DMA, sound in priority order
    slot_if b1_bus [1] ();

    assign main_cs   = main_ram_cs | main_vram_cs;
    assign main_addr = (main_ram_cs ? WRAM_OFFSET : VRAM_OFFSET) + sdram_addr_t'(main_ram_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) refresh_en <= 1'b0;
        else         refresh_en <= ~lvbl & vram_rfsh_en;
    end

    mem_slot #(.AW(23), .DW(16), .OFFSET('0)) u_main (
        .clk(clk), .arst_n(arst_n),
        .cs(main_cs), .we(~main_rnw), .addr(main_addr),
        .din(main_dout), .wrmask(~dsn), .clr(1'b0),
        .ok(main_ram_ok), .dout(main_ram_data), .bus(b0_bus[0])
    );

    mem_slot #(.AW(RAM_AW), .DW(16), .OFFSET(VRAM_OFFSET)) u_dma (
        .clk(clk), .arst_n(arst_n),
        .cs(vram_dma_cs), .we(1'b0), .addr(vram_dma_addr),
        .din('0), .wrmask('0), .clr(vram_clr),
        .ok(vram_dma_ok), .dout(vram_dma_data), .bus(b0_bus[1])
    );

    mem_slot #(.AW(SND_AW), .DW(8), .OFFSET(SND_OFFSET)) u_snd (
        .clk(clk), .arst_n(arst_n),
        .cs(snd_cs), .we(1'b0), .addr(snd_addr),
        .din('0), .wrmask('0), .clr(1'b0),
        .ok(snd_ok), .dout(snd_data), .bus(b0_bus[2])
    );

    mem_slot #(.AW(PCM_AW), .DW(8), .OFFSET(PCM_OFFSET)) u_pcm (
        .clk(clk), .arst_n(arst_n),
        .cs(pcm_cs), .we(1'b0), .addr(pcm_addr),
        .din('0), .wrmask('0), .clr(1'b0),
        .ok(pcm_ok), .dout(pcm_data), .bus(b1_bus[0])
    );

    bank_arbiter #(.NSLOT(3)) u_bank0 (
        .clk(clk), .arst_n(arst_n),
        .ack(ba0_ack), .rdy(ba0_rdy), .data_read(data_read),
        .sdram_addr(ba0_addr), .sdram_rd(ba0_rd), .sdram_wr(ba0_wr),
        .sdram_din(ba0_din), .sdram_mask(ba0_din_m),
        .slots(b0_bus)
    );

    // Read-only bank, write side left open
    bank_arbiter #(.NSLOT(1)) u_bank1 (
        .clk(clk), .arst_n(arst_n),
        .ack(ba1_ack), .rdy(ba1_rdy), .data_read(data_read),
        .sdram_addr(ba1_addr), .sdram_rd(ba1_rd), .sdram_wr(),
        .sdram_din(), .sdram_mask(),
        .slots(b1_bus)
    );

endmodule

// File: tb/mem_map_sva.sv
// Bound assertions on the SDRAM request rules of a bank arbiter
`timescale 1ns/1ns

module mem_map_sva (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   ack,
    input logic                   in_idle,
    input logic                   sdram_rd,
    input logic                   sdram_wr,
    input sdram_pkg::sdram_addr_t sdram_addr
);

    int fails = 0;

    rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(sdram_rd && sdram_wr))
        else begin
            $error("rd and wr high together");
            fails++;
        end

    // Address held until the controller takes it
    addr_hold: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_rd && !ack |=> $stable(sdram_addr))
        else begin
            $error("address changed while rd waits for ack");
            fails++;
        end

    idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        in_idle |-> !sdram_rd && !sdram_wr)
        else begin
            $error("rd or wr high in idle");
            fails++;
        end

endmodule

bind bank_arbiter mem_map_sva u_sva (
    .clk(clk), .arst_n(arst_n), .ack(ack), .in_idle(state == idle),
    .sdram_rd(sdram_rd), .sdram_wr(sdram_wr), .sdram_addr(sdram_addr)
);

// File: tb/tb_mem_map.sv
// Testbench with SDRAM bank models, vector reader, data checks and timeout
`timescale 1ns/1ns

module tb_mem_map;
    import sdram_pkg::*;
    import mem_map_pkg::*;

    localparam int NCOL       = 7;   // Values per vector line
    localparam int MAXV       = 64;
    localparam int RST_CYCLES = 10;

    logic        clk = 1'b0;
    logic        arst_n, lvbl, vram_rfsh_en, vram_clr;
    logic        main_ram_cs, main_vram_cs, main_rnw, vram_dma_cs, snd_cs, pcm_cs;
    ram_addr_t   main_ram_addr, vram_dma_addr;
    snd_addr_t   snd_addr;
    pcm_addr_t   pcm_addr;
    sdram_data_t main_dout, main_ram_data, vram_dma_data, data_read, ba0_din;
    sdram_mask_t dsn, ba0_din_m;
    logic [7:0]  snd_data, pcm_data;
    logic        main_ram_ok, vram_dma_ok, snd_ok, pcm_ok, refresh_en;
    sdram_addr_t ba0_addr, ba1_addr;
    logic        ba0_rd, ba0_wr, ba0_ack, ba0_rdy, ba1_rd, ba1_ack, ba1_rdy;

    logic [23:0] vec_mem [NCOL*MAXV];
    sdram_addr_t wlog_addr [$];  // Bank 0 writes in order with the newest last
    sdram_data_t wlog_data [$];
    logic [15:0] rnd_mem = 16'd60;
    logic [15:0] rnd_vb  = 16'd60;
    logic [15:0] exp_d [4];
    logic [3:0]  pend = '0;
    logic [3:0]  chk;
    logic        exp_rf, rf_armed = 1'b0;
    int          nv, vi, limit = 0, cycles = 0;
    int          err_data = 0, err_rf = 0, err_rst = 0, err_sva = 0;

    mem_map_top UUT (.*);

    always #2 clk = ~clk;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_delay(output int d);
        rnd_mem = lfsr_next(rnd_mem);
        d = rnd_mem[0] ? 2 : 0;
        rnd_mem = lfsr_next(rnd_mem);
        d += rnd_mem[0];
    endtask

    function automatic sdram_data_t mem_read(input int b, input sdram_addr_t a);
        sdram_data_t d;
        d = a[15:0] ^ {1'b0, a[22:16], 8'h00} ^ 16'h5a5a;  // Fill pattern
        for (int i = 0; i < wlog_addr.size(); i++) begin
            if (b == 0 && wlog_addr[i] == a) d = wlog_data[i];
        end
        return d;
    endfunction

    task automatic mem_write(input sdram_addr_t a, input sdram_data_t d, input sdram_mask_t m);
        sdram_data_t old;
        old = mem_read(0, a);
        wlog_addr.push_back(a);
        wlog_data.push_back({m[1] ? old[15:8] : d[15:8], m[0] ? old[7:0] : d[7:0]});
    endtask

    // One access on a bank with ack and rdy after random delays
    task automatic serve_bank(input int b);
        sdram_addr_t a;
        int          dly;
        a = (b == 0) ? ba0_addr : ba1_addr;
        draw_delay(dly);
        repeat (dly) begin
            @(posedge clk);
            #1;
        end
        if (b == 0) ba0_ack = 1'b1;
        else ba1_ack = 1'b1;
        if (b == 0 && ba0_wr) begin
            mem_write(a, ba0_din, ba0_din_m);
        end else begin
            draw_delay(dly);
            repeat (dly) begin
                @(posedge clk);
                #1;
                {ba0_ack, ba1_ack} = 2'b00;
            end
            data_read = mem_read(b, a);
            if (b == 0) ba0_rdy = 1'b1;
            else ba1_rdy = 1'b1;
        end
        @(posedge clk);
        #1;
        {ba0_ack, ba0_rdy, ba1_ack, ba1_rdy} = '0;
    endtask

    // Both banks share data_read, so one access runs at a time
    initial begin
        {ba0_ack, ba0_rdy, ba1_ack, ba1_rdy} = '0;
        data_read = '0;
        forever begin
            if (ba0_rd || ba0_wr) serve_bank(0);
            else if (ba1_rd) serve_bank(1);
            else begin
                @(posedge clk);
                #1;
            end
        end
    end

    task automatic start_op(input int cl, input logic we, input logic [23:0] addr,
                            input sdram_data_t wd, input sdram_mask_t ds, input logic [15:0] ex);
        int p;
        p = (cl < 2) ? 0 : cl - 1;
        case (cl)
            0, 1: begin
                main_ram_cs   = (cl == 0);
                main_vram_cs  = (cl == 1);
                main_rnw      = !we;
                main_ram_addr = addr[16:0];
                main_dout     = wd;
                dsn           = ds;
            end
            2: begin
                vram_dma_cs   = 1'b1;
                vram_dma_addr = addr[16:0];
            end
            3: begin
                snd_cs   = 1'b1;
                snd_addr = addr[15:0];
            end
            default: begin
                pcm_cs   = 1'b1;
                pcm_addr = addr[17:0];
            end
        endcase
        pend[p]  = 1'b1;
        chk[p]   = !we;  // Write replies carry no data
        exp_d[p] = ex;
    endtask

    task automatic release_cs();
        {main_ram_cs, main_vram_cs, vram_dma_cs, snd_cs, pcm_cs} = '0;
        main_rnw = 1'b1;
    endtask

    function automatic logic [16:0] port_reply(input int p);
        case (p)
            0: return {main_ram_ok, main_ram_data};
            1: return {vram_dma_ok, vram_dma_data};
            2: return {snd_ok, 8'h00, snd_data};
            default: return {pcm_ok, 8'h00, pcm_data};
        endcase
    endfunction

    task automatic wait_ops();
        logic [16:0] r;
        while (pend != 0) begin
            @(negedge clk);
            for (int p = 0; p < 4; p++) begin
                r = port_reply(p);
                if (pend[p] && r[16]) begin
                    pend[p] = 1'b0;
                    if (chk[p] && r[15:0] !== exp_d[p]) begin
                        $display("FAILED %0t: vector %0d port %0d read %h, expected %h",
                                 $time, vi, p, r[15:0], exp_d[p]);
                        err_data++;
                    end
                end
            end
        end
    endtask

    // Refresh inputs change every cycle and refresh_en is checked one cycle later
    always @(posedge clk) begin
        exp_rf   <= ~lvbl & vram_rfsh_en;
        rf_armed <= arst_n;
        #1;
        rnd_vb       = lfsr_next(rnd_vb);
        lvbl         = rnd_vb[0];
        rnd_vb       = lfsr_next(rnd_vb);
        vram_rfsh_en = rnd_vb[0];
    end

    always @(negedge clk) begin
        if (rf_armed && refresh_en !== exp_rf) begin
            $display("FAILED %0t: refresh_en is %b, expected %b", $time, refresh_en, exp_rf);
            err_rf++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout, the run is still busy after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        arst_n       = 1'b0;
        lvbl         = 1'b1;
        vram_rfsh_en = 1'b0;
        vram_clr     = 1'b0;
        release_cs();
        {main_ram_addr, vram_dma_addr, snd_addr, pcm_addr} = '0;
        {main_dout, dsn} = '0;
        $readmemh("tb/mem_map_vectors.txt", vec_mem);
        nv = 0;
        while (nv < MAXV && vec_mem[nv*NCOL] !== 24'hf) nv++;
        limit = nv * 16 + RST_CYCLES;

        repeat (RST_CYCLES) @(posedge clk);
        #1;
        if ({main_ram_ok, vram_dma_ok, snd_ok, pcm_ok, ba0_rd, ba0_wr, ba1_rd, refresh_en}
            !== 8'h00) begin
            $display("FAILED %0t: outputs not all low during reset", $time);
            err_rst++;
        end
        arst_n = 1'b1;

        for (vi = 0; vi < nv; vi++) begin
            if (pend == 0) begin
                @(posedge clk);
                #1;
            end
            if (vec_mem[vi*NCOL] == 24'h5) begin
                vram_clr = 1'b1;  // One cycle pulse
                @(posedge clk);
                #1;
                vram_clr = 1'b0;
            end else begin
                start_op(vec_mem[vi*NCOL], vec_mem[vi*NCOL+1][0], vec_mem[vi*NCOL+2],
                         vec_mem[vi*NCOL+3][15:0], vec_mem[vi*NCOL+4][1:0],
                         vec_mem[vi*NCOL+5][15:0]);
            end
            if (vec_mem[vi*NCOL+6] == 24'h0) begin
                wait_ops();
                @(posedge clk);
                #1;
                release_cs();
            end
        end

        repeat (4) @(posedge clk);
        err_sva = UUT.u_bank0.u_sva.fails + UUT.u_bank1.u_sva.fails;
        $display("Errors: %0d data, %0d refresh, %0d reset, %0d assertion",
                 err_data, err_rf, err_rst, err_sva);
        if (err_data + err_rf + err_rst + err_sva == 0) $display("TEST PASSED");
        else $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tb/mem_map_vectors.txt
// Columns are client, write flag, address, write data, dsn, expected data and group flag
// Clients 0 work RAM, 1 VRAM, 2 DMA, 3 sound, 4 PCM, 5 vram_clr pulse, f end of list
// A group flag of 1 starts the next line in the same cycle
0 0 00010 0000 0 6a4a 0
0 0 10004 0000 0 6b5e 0
1 0 0abcd 0000 0 d197 0
0 0 00020 0000 0 6a7a 0
0 1 00020 1234 1 0000 0
0 0 00020 0000 0 6a34 0
0 1 00030 beef 2 0000 0
0 0 00030 0000 0 be6a 0
3 0 00100 0000 0 0062 0
3 0 00101 0000 0 00da 0
3 0 01235 0000 0 0040 0
4 0 00010 0000 0 005a 0
4 0 2abcd 0000 0 00bc 0
0 0 00400 0000 0 6e5a 1
2 0 00200 0000 0 785a 1
3 0 00a02 0000 0 0067 1
4 0 00101 0000 0 00da 0
0 1 00500 cafe 3 0000 1
2 0 00500 0000 0 7f5a 1
3 0 00001 0000 0 005a 0
0 0 00500 0000 0 cafe 0
2 0 00040 0000 0 7a1a 0
1 1 00040 7777 3 0000 0
2 0 00040 0000 0 7a1a 0
1 0 00040 0000 0 7777 0
5 0 00000 0000 0 0000 0
2 0 00040 0000 0 7777 0
f 0 00000 0000 0 0000 0

// File: filelist.f
hdl/sdram_pkg.sv
hdl/mem_map_pkg.sv
hdl/slot_if.sv
hdl/mem_slot.sv
hdl/bank_arbiter.sv
hdl/mem_map_top.sv
tb/mem_map_sva.sv
tb/tb_mem_map.sv
